// ==== hdl/mc_bridge.sv ====
//////////////////////////////////////////////////////////////////////
// writes are posted; only reads produce a response
//////////////////////////////////////////////////////////////////////
`include "mc_bridge_defs.svh"
`timescale 1ns/1ps
`default_nettype none

module mc_bridge (
  input  wire logic                                       clk_i,
  input  wire logic                                       reset_i,
  input  wire logic                                       cmd_v_i,
  input  wire mc_bridge_pkg::mem_op_e                     cmd_op_i,
  input  wire mc_bridge_pkg::nc_size_e                    cmd_size_i,
  input  wire logic [`MC_PADDR_W-1:0]                     cmd_addr_i,
  input  wire logic [`MC_BLOCK_WORDS-1:0][`MC_WORD_W-1:0] cmd_data_i,
  output logic                                            cmd_yumi_o,
  output logic                                            pkt_v_o,
  output mc_bridge_pkg::pkt_op_e                          pkt_op_o,
  output logic [`MC_X_W-1:0]                              pkt_x_o,
  output logic [`MC_Y_W-1:0]                              pkt_y_o,
  output logic [`MC_LINK_ADDR_W-1:0]                      pkt_addr_o,
  output logic [`MC_WORD_W-1:0]                           pkt_data_o,
  input  wire logic                                       credit_i,
  input  wire logic                                       return_v_i,
  input  wire logic [`MC_WORD_W-1:0]                      return_data_i,
  output logic                                            resp_v_o,
  output logic [`MC_PADDR_W-1:0]                          resp_addr_o,
  output logic [`MC_BLOCK_WORDS-1:0][`MC_WORD_W-1:0]      resp_data_o,
  input  wire logic                                       resp_ready_i
);

  logic ld_yumi, st_yumi;
  logic ld_req_v, st_req_v, ld_grant, st_grant;
  mc_bridge_pkg::pkt_op_e ld_req_op, st_req_op;
  logic [`MC_X_W-1:0] ld_req_x, st_req_x;
  logic [`MC_Y_W-1:0] ld_req_y, st_req_y;
  logic [`MC_LINK_ADDR_W-1:0] ld_req_addr, st_req_addr;
  logic [`MC_WORD_W-1:0] ld_req_data, st_req_data;
  logic [$clog2(`MC_BLOCK_WORDS+1)-1:0] sipo_count;
  logic [`MC_BLOCK_WORDS-1:0][`MC_WORD_W-1:0] sipo_data;
  logic sipo_consume;

  // units never accept in the same cycle, opcodes differ
  assign cmd_yumi_o = ld_yumi || st_yumi;

  mc_load_unit u_load (
    .clk_i(clk_i), .reset_i(reset_i),
    .cmd_v_i(cmd_v_i), .cmd_op_i(cmd_op_i), .cmd_size_i(cmd_size_i),
    .cmd_addr_i(cmd_addr_i), .cmd_yumi_o(ld_yumi),
    .req_v_o(ld_req_v), .req_op_o(ld_req_op), .req_x_o(ld_req_x), .req_y_o(ld_req_y),
    .req_addr_o(ld_req_addr), .req_data_o(ld_req_data), .req_grant_i(ld_grant),
    .sipo_count_i(sipo_count), .sipo_data_i(sipo_data), .sipo_consume_o(sipo_consume),
    .resp_v_o(resp_v_o), .resp_addr_o(resp_addr_o), .resp_data_o(resp_data_o),
    .resp_ready_i(resp_ready_i)
  );

  mc_store_unit u_store (
    .clk_i(clk_i), .reset_i(reset_i),
    .cmd_v_i(cmd_v_i), .cmd_op_i(cmd_op_i), .cmd_size_i(cmd_size_i),
    .cmd_addr_i(cmd_addr_i), .cmd_data_i(cmd_data_i), .cmd_yumi_o(st_yumi),
    .req_v_o(st_req_v), .req_op_o(st_req_op), .req_x_o(st_req_x), .req_y_o(st_req_y),
    .req_addr_o(st_req_addr), .req_data_o(st_req_data), .req_grant_i(st_grant)
  );

  mc_link_arbiter u_arb (
    .clk_i(clk_i), .reset_i(reset_i),
    .ld_req_v_i(ld_req_v), .ld_req_op_i(ld_req_op), .ld_req_x_i(ld_req_x),
    .ld_req_y_i(ld_req_y), .ld_req_addr_i(ld_req_addr), .ld_req_data_i(ld_req_data),
    .st_req_v_i(st_req_v), .st_req_op_i(st_req_op), .st_req_x_i(st_req_x),
    .st_req_y_i(st_req_y), .st_req_addr_i(st_req_addr), .st_req_data_i(st_req_data),
    .credit_i(credit_i), .ld_grant_o(ld_grant), .st_grant_o(st_grant),
    .pkt_v_o(pkt_v_o), .pkt_op_o(pkt_op_o), .pkt_x_o(pkt_x_o), .pkt_y_o(pkt_y_o),
    .pkt_addr_o(pkt_addr_o), .pkt_data_o(pkt_data_o)
  );

  mc_return_sipo u_sipo (
    .clk_i(clk_i), .reset_i(reset_i),
    .in_v_i(return_v_i), .in_data_i(return_data_i), .consume_i(sipo_consume),
    .count_o(sipo_count), .data_o(sipo_data)
  );

endmodule

`default_nettype wire

// ==== hdl/mc_bridge_defs.svh ====
//////////////////////////////////////////////////////////////////////
// widths and sizes shared by the bridge; coordinate offsets assume
// 2 byte-offset bits followed by the 12-bit packet word address
//////////////////////////////////////////////////////////////////////
`ifndef MC_BRIDGE_DEFS_SVH
`define MC_BRIDGE_DEFS_SVH

`define MC_WORD_W        32
`define MC_BLOCK_WORDS   4
`define MC_PADDR_W       32
`define MC_LINK_ADDR_W   12

// mesh coordinates taken from the command address
`define MC_X_W           2
`define MC_Y_W           2
`define MC_X_OFFSET      14
`define MC_Y_OFFSET      16

`define MC_LINK_CREDITS  4

`endif

// ==== hdl/mc_bridge_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// command and packet encodings, all one bit wide
//////////////////////////////////////////////////////////////////////
`default_nettype none

package mc_bridge_pkg;

  // command from the coherence engine
  typedef enum logic {
    MEM_READ  = 1'b0,
    MEM_WRITE = 1'b1
  } mem_op_e;

  // NC_BLOCK marks a cached block command
  typedef enum logic {
    NC_WORD  = 1'b0,
    NC_BLOCK = 1'b1
  } nc_size_e;

  // remote packet opcode on the mesh link
  typedef enum logic {
    PKT_LOAD  = 1'b0,
    PKT_STORE = 1'b1
  } pkt_op_e;

endpackage

`default_nettype wire

// ==== hdl/mc_link_arbiter.sv ====
//////////////////////////////////////////////////////////////////////
// grants only with a credit; one credit_i pulse per consumed packet
//////////////////////////////////////////////////////////////////////
`include "mc_bridge_defs.svh"
`timescale 1ns/1ps
`default_nettype none

module mc_link_arbiter (
  input  wire logic                          clk_i,
  input  wire logic                          reset_i,
  input  wire logic                          ld_req_v_i,
  input  wire mc_bridge_pkg::pkt_op_e        ld_req_op_i,
  input  wire logic [`MC_X_W-1:0]            ld_req_x_i,
  input  wire logic [`MC_Y_W-1:0]            ld_req_y_i,
  input  wire logic [`MC_LINK_ADDR_W-1:0]    ld_req_addr_i,
  input  wire logic [`MC_WORD_W-1:0]         ld_req_data_i,
  input  wire logic                          st_req_v_i,
  input  wire mc_bridge_pkg::pkt_op_e        st_req_op_i,
  input  wire logic [`MC_X_W-1:0]            st_req_x_i,
  input  wire logic [`MC_Y_W-1:0]            st_req_y_i,
  input  wire logic [`MC_LINK_ADDR_W-1:0]    st_req_addr_i,
  input  wire logic [`MC_WORD_W-1:0]         st_req_data_i,
  input  wire logic                          credit_i,
  output logic                               ld_grant_o,
  output logic                               st_grant_o,
  output logic                               pkt_v_o,
  output mc_bridge_pkg::pkt_op_e             pkt_op_o,
  output logic [`MC_X_W-1:0]                 pkt_x_o,
  output logic [`MC_Y_W-1:0]                 pkt_y_o,
  output logic [`MC_LINK_ADDR_W-1:0]         pkt_addr_o,
  output logic [`MC_WORD_W-1:0]              pkt_data_o
);

  localparam int cred_w = $clog2(`MC_LINK_CREDITS + 1);

  logic [cred_w-1:0] credit_cnt_r;
  // high gives the store unit priority
  logic ptr_r;
  logic has_credit;

  assign has_credit = (credit_cnt_r != '0);
  assign ld_grant_o = has_credit && ld_req_v_i && (!st_req_v_i || !ptr_r);
  assign st_grant_o = has_credit && st_req_v_i && (!ld_req_v_i || ptr_r);

  assign pkt_v_o    = ld_grant_o || st_grant_o;
  assign pkt_op_o   = st_grant_o ? st_req_op_i   : ld_req_op_i;
  assign pkt_x_o    = st_grant_o ? st_req_x_i    : ld_req_x_i;
  assign pkt_y_o    = st_grant_o ? st_req_y_i    : ld_req_y_i;
  assign pkt_addr_o = st_grant_o ? st_req_addr_i : ld_req_addr_i;
  assign pkt_data_o = st_grant_o ? st_req_data_i : ld_req_data_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      credit_cnt_r <= cred_w'(`MC_LINK_CREDITS);
      ptr_r        <= 1'b0;
    end else begin
      case ({pkt_v_o, credit_i})
        2'b10:   credit_cnt_r <= credit_cnt_r - 1'b1;
        2'b01:   credit_cnt_r <= credit_cnt_r + 1'b1;
        default: credit_cnt_r <= credit_cnt_r;
      endcase
      if (ld_grant_o) begin
        ptr_r <= 1'b1;
      end else if (st_grant_o) begin
        ptr_r <= 1'b0;
      end
    end
  end

  // a wrap below zero also lands above the limit
  assert property (@(posedge clk_i) disable iff (reset_i)
    credit_cnt_r <= cred_w'(`MC_LINK_CREDITS));

  assert property (@(posedge clk_i) disable iff (reset_i) !(ld_grant_o && st_grant_o));

endmodule

`default_nettype wire

// ==== hdl/mc_load_unit.sv ====
//////////////////////////////////////////////////////////////////////
// one read in flight; response waits for all words in the return SIPO
//////////////////////////////////////////////////////////////////////
`include "mc_bridge_defs.svh"
`timescale 1ns/1ps
`default_nettype none

module mc_load_unit (
  input  wire logic                                    clk_i,
  input  wire logic                                    reset_i,
  input  wire logic                                    cmd_v_i,
  input  wire mc_bridge_pkg::mem_op_e                  cmd_op_i,
  input  wire mc_bridge_pkg::nc_size_e                 cmd_size_i,
  input  wire logic [`MC_PADDR_W-1:0]                  cmd_addr_i,
  output logic                                         cmd_yumi_o,
  output logic                                         req_v_o,
  output mc_bridge_pkg::pkt_op_e                       req_op_o,
  output logic [`MC_X_W-1:0]                           req_x_o,
  output logic [`MC_Y_W-1:0]                           req_y_o,
  output logic [`MC_LINK_ADDR_W-1:0]                   req_addr_o,
  output logic [`MC_WORD_W-1:0]                        req_data_o,
  input  wire logic                                    req_grant_i,
  input  wire logic [$clog2(`MC_BLOCK_WORDS+1)-1:0]    sipo_count_i,
  input  wire logic [`MC_BLOCK_WORDS-1:0][`MC_WORD_W-1:0] sipo_data_i,
  output logic                                         sipo_consume_o,
  output logic                                         resp_v_o,
  output logic [`MC_PADDR_W-1:0]                       resp_addr_o,
  output logic [`MC_BLOCK_WORDS-1:0][`MC_WORD_W-1:0]   resp_data_o,
  input  wire logic                                    resp_ready_i
);

  localparam int fill_w   = $clog2(`MC_BLOCK_WORDS + 1);
  localparam int lg_words = $clog2(`MC_BLOCK_WORDS);
  localparam int byte_off = `MC_X_OFFSET - `MC_LINK_ADDR_W;

  typedef enum logic [2:0] {
    LD_IDLE,
    LD_SEND_BLOCK,
    LD_WAIT_BLOCK,
    LD_SEND_WORD,
    LD_WAIT_WORD
  } ld_state_e;

  ld_state_e state_r, state_n;
  logic [lg_words-1:0] cnt_r, cnt_n;
  logic [`MC_PADDR_W-1:0] addr_r;
  logic [`MC_LINK_ADDR_W-1:0] word_addr;

  assign word_addr  = addr_r[byte_off +: `MC_LINK_ADDR_W];
  assign req_x_o    = addr_r[`MC_X_OFFSET +: `MC_X_W];
  assign req_y_o    = addr_r[`MC_Y_OFFSET +: `MC_Y_W];
  assign req_op_o   = mc_bridge_pkg::PKT_LOAD;
  assign req_data_o = '0;
  assign resp_addr_o = addr_r;

  always_comb begin
    state_n        = state_r;
    cnt_n          = cnt_r;
    cmd_yumi_o     = 1'b0;
    req_v_o        = 1'b0;
    req_addr_o     = word_addr;
    sipo_consume_o = 1'b0;
    resp_v_o       = 1'b0;
    resp_data_o    = sipo_data_i;
    case (state_r)
      LD_IDLE: begin
        if (cmd_v_i && cmd_op_i == mc_bridge_pkg::MEM_READ) begin
          cmd_yumi_o = 1'b1;
          cnt_n      = '0;
          state_n    = (cmd_size_i == mc_bridge_pkg::NC_BLOCK) ? LD_SEND_BLOCK : LD_SEND_WORD;
        end
      end
      LD_SEND_BLOCK: begin
        // block base with the word counter in the low bits
        req_v_o    = 1'b1;
        req_addr_o = {word_addr[`MC_LINK_ADDR_W-1:lg_words], cnt_r};
        if (req_grant_i) begin
          cnt_n = cnt_r + 1'b1;
          if (cnt_r == lg_words'(`MC_BLOCK_WORDS - 1)) begin
            state_n = LD_WAIT_BLOCK;
          end
        end
      end
      LD_WAIT_BLOCK: begin
        resp_v_o = (sipo_count_i == fill_w'(`MC_BLOCK_WORDS));
        if (resp_v_o && resp_ready_i) begin
          sipo_consume_o = 1'b1;
          state_n        = LD_IDLE;
        end
      end
      LD_SEND_WORD: begin
        req_v_o = 1'b1;
        if (req_grant_i) begin
          state_n = LD_WAIT_WORD;
        end
      end
      LD_WAIT_WORD: begin
        resp_data_o    = '0;
        resp_data_o[0] = sipo_data_i[0];
        resp_v_o       = (sipo_count_i == fill_w'(1));
        if (resp_v_o && resp_ready_i) begin
          sipo_consume_o = 1'b1;
          state_n        = LD_IDLE;
        end
      end
      default: state_n = LD_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= LD_IDLE;
      cnt_r   <= '0;
    end else begin
      state_r <= state_n;
      cnt_r   <= cnt_n;
    end
  end

  always_ff @(posedge clk_i) begin
    if (cmd_yumi_o) begin
      addr_r <= cmd_addr_i;
    end
  end

  // arbiter must only grant a live request
  assert property (@(posedge clk_i) disable iff (reset_i) req_grant_i |-> req_v_o);

endmodule

`default_nettype wire

// ==== hdl/mc_return_sipo.sv ====
//////////////////////////////////////////////////////////////////////
// no ready output; the sender must never exceed the lane count
//////////////////////////////////////////////////////////////////////
`include "mc_bridge_defs.svh"
`timescale 1ns/1ps
`default_nettype none

module mc_return_sipo (
  input  wire logic                                    clk_i,
  input  wire logic                                    reset_i,
  input  wire logic                                    in_v_i,
  input  wire logic [`MC_WORD_W-1:0]                   in_data_i,
  input  wire logic                                    consume_i,
  output logic [$clog2(`MC_BLOCK_WORDS+1)-1:0]         count_o,
  output logic [`MC_BLOCK_WORDS-1:0][`MC_WORD_W-1:0]   data_o
);

  localparam int fill_w = $clog2(`MC_BLOCK_WORDS + 1);

  logic [fill_w-1:0] count_r;
  logic [`MC_BLOCK_WORDS-1:0][`MC_WORD_W-1:0] lanes_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      count_r <= '0;
    end else if (consume_i) begin
      count_r <= '0;
    end else if (in_v_i) begin
      count_r <= count_r + 1'b1;
    end
  end

  // next free lane is the current fill level
  always_ff @(posedge clk_i) begin
    if (in_v_i && !consume_i) begin
      lanes_r[count_r[fill_w-2:0]] <= in_data_i;
    end
  end

  assign count_o = count_r;
  assign data_o  = lanes_r;

  // load unit keeps at most one block outstanding
  assert property (@(posedge clk_i) disable iff (reset_i)
    in_v_i |-> (count_r < fill_w'(`MC_BLOCK_WORDS)));

endmodule

`default_nettype wire

// ==== hdl/mc_store_unit.sv ====
//////////////////////////////////////////////////////////////////////
// posted writes; done once the last store packet is granted
//////////////////////////////////////////////////////////////////////
`include "mc_bridge_defs.svh"
`timescale 1ns/1ps
`default_nettype none

module mc_store_unit (
  input  wire logic                                       clk_i,
  input  wire logic                                       reset_i,
  input  wire logic                                       cmd_v_i,
  input  wire mc_bridge_pkg::mem_op_e                     cmd_op_i,
  input  wire mc_bridge_pkg::nc_size_e                    cmd_size_i,
  input  wire logic [`MC_PADDR_W-1:0]                     cmd_addr_i,
  input  wire logic [`MC_BLOCK_WORDS-1:0][`MC_WORD_W-1:0] cmd_data_i,
  output logic                                            cmd_yumi_o,
  output logic                                            req_v_o,
  output mc_bridge_pkg::pkt_op_e                          req_op_o,
  output logic [`MC_X_W-1:0]                              req_x_o,
  output logic [`MC_Y_W-1:0]                              req_y_o,
  output logic [`MC_LINK_ADDR_W-1:0]                      req_addr_o,
  output logic [`MC_WORD_W-1:0]                           req_data_o,
  input  wire logic                                       req_grant_i
);

  localparam int lg_words = $clog2(`MC_BLOCK_WORDS);
  localparam int byte_off = `MC_X_OFFSET - `MC_LINK_ADDR_W;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SEND_BLOCK,
    ST_SEND_WORD
  } st_state_e;

  st_state_e state_r;
  logic [lg_words-1:0] cnt_r;
  logic [`MC_PADDR_W-1:0] addr_r;
  logic [`MC_BLOCK_WORDS-1:0][`MC_WORD_W-1:0] data_r;
  logic [`MC_LINK_ADDR_W-1:0] word_addr;
  logic last_grant;

  assign word_addr  = addr_r[byte_off +: `MC_LINK_ADDR_W];
  assign cmd_yumi_o = (state_r == ST_IDLE) && cmd_v_i && (cmd_op_i == mc_bridge_pkg::MEM_WRITE);
  assign req_v_o    = (state_r != ST_IDLE);
  assign req_op_o   = mc_bridge_pkg::PKT_STORE;
  assign req_x_o    = addr_r[`MC_X_OFFSET +: `MC_X_W];
  assign req_y_o    = addr_r[`MC_Y_OFFSET +: `MC_Y_W];
  // counter stays at zero for an uncached write, so lane 0 goes out
  assign req_data_o = data_r[cnt_r];
  assign req_addr_o = (state_r == ST_SEND_BLOCK)
                    ? {word_addr[`MC_LINK_ADDR_W-1:lg_words], cnt_r}
                    : word_addr;
  assign last_grant = req_grant_i
                    && ((state_r == ST_SEND_WORD) || (cnt_r == lg_words'(`MC_BLOCK_WORDS - 1)));

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= ST_IDLE;
      cnt_r   <= '0;
    end else if (cmd_yumi_o) begin
      cnt_r   <= '0;
      state_r <= (cmd_size_i == mc_bridge_pkg::NC_BLOCK) ? ST_SEND_BLOCK : ST_SEND_WORD;
    end else if (last_grant) begin
      state_r <= ST_IDLE;
    end else if (req_grant_i) begin
      cnt_r <= cnt_r + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (cmd_yumi_o) begin
      addr_r <= cmd_addr_i;
      data_r <= cmd_data_i;
    end
  end

endmodule

`default_nettype wire

// ==== mc_bridge.f ====
+incdir+hdl
hdl/mc_bridge_pkg.sv
hdl/mc_return_sipo.sv
hdl/mc_load_unit.sv
hdl/mc_store_unit.sv
hdl/mc_link_arbiter.sv
hdl/mc_bridge.sv
tb/mc_node_model.sv
tb/mc_bridge_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal \
  -f mc_bridge.f \
  --top-module mc_bridge_tb \
  -o mc_bridge_sim

./obj_dir/mc_bridge_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Finished with no errors" sim.log; then
  exit 0
fi
exit 1

// ==== tb/mc_bridge_tb.sv ====
//////////////////////////////////////////////////////////////////////
// directed commands then a random mix; stops at the first mismatch
//////////////////////////////////////////////////////////////////////
`include "mc_bridge_defs.svh"
`timescale 1ns/1ps
`default_nettype none

module mc_bridge_tb;

  localparam int num_cmds = 32;
  localparam int num_directed = 8;
  localparam int timeout_cycles = num_cmds * 40;
  localparam int idx_w = `MC_X_W + `MC_Y_W + `MC_LINK_ADDR_W;

  typedef logic [`MC_BLOCK_WORDS-1:0][`MC_WORD_W-1:0] block_t;

  typedef struct packed {
    mc_bridge_pkg::pkt_op_e      op;
    logic [`MC_X_W-1:0]          x;
    logic [`MC_Y_W-1:0]          y;
    logic [`MC_LINK_ADDR_W-1:0]  addr;
    logic [`MC_WORD_W-1:0]       data;
  } exp_pkt_t;

  typedef struct packed {
    logic [`MC_PADDR_W-1:0] addr;
    block_t                 data;
  } exp_resp_t;

  logic clk_i = 1'b0;
  logic reset_i;
  logic cmd_v_i;
  mc_bridge_pkg::mem_op_e cmd_op_i;
  mc_bridge_pkg::nc_size_e cmd_size_i;
  logic [`MC_PADDR_W-1:0] cmd_addr_i;
  block_t cmd_data_i;
  logic cmd_yumi_o;
  logic pkt_v_o;
  mc_bridge_pkg::pkt_op_e pkt_op_o;
  logic [`MC_X_W-1:0] pkt_x_o;
  logic [`MC_Y_W-1:0] pkt_y_o;
  logic [`MC_LINK_ADDR_W-1:0] pkt_addr_o;
  logic [`MC_WORD_W-1:0] pkt_data_o;
  logic credit_i;
  logic return_v_i;
  logic [`MC_WORD_W-1:0] return_data_i;
  logic resp_v_o;
  logic [`MC_PADDR_W-1:0] resp_addr_o;
  block_t resp_data_o;
  logic resp_ready_i;
  int in_flight;

  // command table, response expected for reads only
  mc_bridge_pkg::mem_op_e  tab_op [num_cmds];
  mc_bridge_pkg::nc_size_e tab_size [num_cmds];
  logic [`MC_PADDR_W-1:0]  tab_addr [num_cmds];
  block_t                  tab_data [num_cmds];
  logic                    tab_resp [num_cmds];

  logic [`MC_WORD_W-1:0] ref_mem [0:(1<<idx_w)-1];
  exp_pkt_t load_q [$];
  exp_pkt_t store_q [$];
  exp_resp_t resp_q [$];
  int seed = 32'hd388;
  int cycle_cnt = 0;

  always #50 clk_i = ~clk_i;

  mc_bridge u_mc_bridge (
    .clk_i(clk_i), .reset_i(reset_i),
    .cmd_v_i(cmd_v_i), .cmd_op_i(cmd_op_i), .cmd_size_i(cmd_size_i),
    .cmd_addr_i(cmd_addr_i), .cmd_data_i(cmd_data_i), .cmd_yumi_o(cmd_yumi_o),
    .pkt_v_o(pkt_v_o), .pkt_op_o(pkt_op_o), .pkt_x_o(pkt_x_o), .pkt_y_o(pkt_y_o),
    .pkt_addr_o(pkt_addr_o), .pkt_data_o(pkt_data_o), .credit_i(credit_i),
    .return_v_i(return_v_i), .return_data_i(return_data_i),
    .resp_v_o(resp_v_o), .resp_addr_o(resp_addr_o), .resp_data_o(resp_data_o),
    .resp_ready_i(resp_ready_i)
  );

  mc_node_model u_node (
    .clk_i(clk_i), .reset_i(reset_i),
    .pkt_v_i(pkt_v_o), .pkt_op_i(pkt_op_o), .pkt_x_i(pkt_x_o), .pkt_y_i(pkt_y_o),
    .pkt_addr_i(pkt_addr_o), .pkt_data_i(pkt_data_o),
    .credit_o(credit_i), .return_v_o(return_v_i), .return_data_o(return_data_i),
    .in_flight_o(in_flight)
  );

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [127:0] got,
                                 input logic [127:0] exp);
    $display("ERROR at %0t: %s got %0h expected %0h", $time, name, got, exp);
    abort_run("value mismatch on the DUT outputs");
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) report_mismatch(name, got, exp);
  endtask

  task automatic check_pkt(input mc_bridge_pkg::pkt_op_e got_op,
                           input logic [`MC_X_W-1:0] got_x,
                           input logic [`MC_Y_W-1:0] got_y,
                           input logic [`MC_LINK_ADDR_W-1:0] got_addr,
                           input logic [`MC_WORD_W-1:0] got_data,
                           input exp_pkt_t exp);
    if (got_op !== exp.op) report_mismatch("pkt_op_o", got_op, exp.op);
    if (got_x !== exp.x) report_mismatch("pkt_x_o", got_x, exp.x);
    if (got_y !== exp.y) report_mismatch("pkt_y_o", got_y, exp.y);
    if (got_addr !== exp.addr) report_mismatch("pkt_addr_o", got_addr, exp.addr);
    if (got_data !== exp.data) report_mismatch("pkt_data_o", got_data, exp.data);
  endtask

  task automatic check_resp(input logic [`MC_PADDR_W-1:0] got_addr,
                            input block_t got_data, input exp_resp_t exp);
    if (got_addr !== exp.addr) report_mismatch("resp_addr_o", got_addr, exp.addr);
    if (got_data !== exp.data) report_mismatch("resp_data_o", got_data, exp.data);
  endtask

  task automatic set_cmd(input int i, input mc_bridge_pkg::mem_op_e op,
                         input mc_bridge_pkg::nc_size_e size,
                         input logic [`MC_PADDR_W-1:0] addr, input block_t data);
    tab_op[i]   = op;
    tab_size[i] = size;
    tab_addr[i] = addr;
    tab_data[i] = data;
    tab_resp[i] = (op == mc_bridge_pkg::MEM_READ);
  endtask

  // drive one table entry and record what the link and response must show
  task automatic issue_cmd(input int i);
    logic [`MC_LINK_ADDR_W-1:0] wa;
    logic [`MC_LINK_ADDR_W-1:0] word_wa;
    logic [idx_w-1:0] idx;
    exp_pkt_t p;
    exp_resp_t r;
    int n;
    // keep reads and writes to one word in link order
    if (tab_op[i] == mc_bridge_pkg::MEM_READ) begin
      while (store_q.size() != 0) @(negedge clk_i);
    end else begin
      while (load_q.size() != 0) @(negedge clk_i);
    end
    @(posedge clk_i);
    cmd_v_i    <= 1'b1;
    cmd_op_i   <= tab_op[i];
    cmd_size_i <= tab_size[i];
    cmd_addr_i <= tab_addr[i];
    cmd_data_i <= tab_data[i];
    @(negedge clk_i);
    while (!cmd_yumi_o) @(negedge clk_i);
    wa = tab_addr[i][`MC_X_OFFSET-1 -: `MC_LINK_ADDR_W];
    n = (tab_size[i] == mc_bridge_pkg::NC_BLOCK) ? `MC_BLOCK_WORDS : 1;
    r.addr = tab_addr[i];
    r.data = '0;
    for (int k = 0; k < n; k++) begin
      word_wa = (n == 1) ? wa : ((wa & ~`MC_LINK_ADDR_W'(`MC_BLOCK_WORDS - 1))
                                 | `MC_LINK_ADDR_W'(k));
      idx = {tab_addr[i][`MC_Y_OFFSET +: `MC_Y_W], tab_addr[i][`MC_X_OFFSET +: `MC_X_W],
             word_wa};
      p.x    = tab_addr[i][`MC_X_OFFSET +: `MC_X_W];
      p.y    = tab_addr[i][`MC_Y_OFFSET +: `MC_Y_W];
      p.addr = word_wa;
      if (tab_op[i] == mc_bridge_pkg::MEM_READ) begin
        p.op = mc_bridge_pkg::PKT_LOAD;
        p.data = '0;
        r.data[k] = ref_mem[idx];
        load_q.push_back(p);
      end else begin
        p.op = mc_bridge_pkg::PKT_STORE;
        p.data = tab_data[i][k];
        ref_mem[idx] = tab_data[i][k];
        store_q.push_back(p);
      end
    end
    if (tab_resp[i]) resp_q.push_back(r);
    @(posedge clk_i);
    cmd_v_i <= 1'b0;
  endtask

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= timeout_cycles) begin
      abort_run("timeout: the command table did not complete in time");
    end
  end

  always @(posedge clk_i) begin
    if (reset_i) begin
      resp_ready_i <= 1'b0;
    end else begin
      resp_ready_i <= ($unsigned($random(seed)) % 4) != 0;
    end
  end

  // outputs are sampled mid-cycle where they are settled
  always @(negedge clk_i) begin
    if (!reset_i) begin
      if (in_flight > `MC_LINK_CREDITS) begin
        abort_run("more packets in flight than link credits");
      end
      if (pkt_v_o) begin
        // loads and stores are never pending together
        if (load_q.size() != 0) begin
          check_pkt(pkt_op_o, pkt_x_o, pkt_y_o, pkt_addr_o, pkt_data_o, load_q.pop_front());
        end else if (store_q.size() != 0) begin
          check_pkt(pkt_op_o, pkt_x_o, pkt_y_o, pkt_addr_o, pkt_data_o, store_q.pop_front());
        end else begin
          abort_run("unexpected packet on the link");
        end
      end
      if (resp_v_o && resp_ready_i) begin
        if (resp_q.size() == 0) abort_run("response without a pending read");
        check_resp(resp_addr_o, resp_data_o, resp_q.pop_front());
      end
    end
  end

  initial begin
    block_t rnd_data;
    logic [`MC_PADDR_W-1:0] rnd_addr;
    reset_i = 1'b1;
    cmd_v_i = 1'b0;
    cmd_op_i = mc_bridge_pkg::MEM_READ;
    cmd_size_i = mc_bridge_pkg::NC_WORD;
    cmd_addr_i = '0;
    cmd_data_i = '0;
    resp_ready_i = 1'b0;
    for (int i = 0; i < (1 << idx_w); i++) begin
      ref_mem[i] = i ^ 32'ha5c3_96e1;
    end

    set_cmd(0, mc_bridge_pkg::MEM_READ, mc_bridge_pkg::NC_BLOCK, 32'h0001_4020, '0);
    set_cmd(1, mc_bridge_pkg::MEM_READ, mc_bridge_pkg::NC_WORD, 32'h0001_4024, '0);
    set_cmd(2, mc_bridge_pkg::MEM_WRITE, mc_bridge_pkg::NC_BLOCK, 32'h0001_4020,
            {32'h4444_0004, 32'h3333_0003, 32'h2222_0002, 32'h1111_0001});
    set_cmd(3, mc_bridge_pkg::MEM_READ, mc_bridge_pkg::NC_BLOCK, 32'h0001_4028, '0);
    set_cmd(4, mc_bridge_pkg::MEM_WRITE, mc_bridge_pkg::NC_WORD, 32'h0002_8044,
            {96'h0, 32'hcafe_0044});
    set_cmd(5, mc_bridge_pkg::MEM_READ, mc_bridge_pkg::NC_WORD, 32'h0002_8044, '0);
    set_cmd(6, mc_bridge_pkg::MEM_READ, mc_bridge_pkg::NC_BLOCK, 32'h0002_8040, '0);
    set_cmd(7, mc_bridge_pkg::MEM_READ, mc_bridge_pkg::NC_WORD, 32'h0003_c008, '0);
    // random mix over a small window so addresses repeat
    for (int i = num_directed; i < num_cmds; i++) begin
      rnd_addr = '0;
      rnd_addr[`MC_X_OFFSET +: `MC_X_W] = $random(seed);
      rnd_addr[`MC_Y_OFFSET +: `MC_Y_W] = $random(seed);
      rnd_addr[4:2] = $random(seed);
      for (int k = 0; k < `MC_BLOCK_WORDS; k++) begin
        rnd_data[k] = $random(seed);
      end
      set_cmd(i, mc_bridge_pkg::mem_op_e'($random(seed) & 1),
              mc_bridge_pkg::nc_size_e'($random(seed) & 1), rnd_addr, rnd_data);
    end

    repeat (16) @(posedge clk_i);
    reset_i <= 1'b0;
    @(negedge clk_i);
    check_flag("cmd_yumi_o", cmd_yumi_o, 1'b0);
    check_flag("pkt_v_o", pkt_v_o, 1'b0);
    check_flag("resp_v_o", resp_v_o, 1'b0);

    for (int i = 0; i < num_cmds; i++) begin
      issue_cmd(i);
    end
    while (load_q.size() != 0 || store_q.size() != 0 || resp_q.size() != 0) begin
      @(negedge clk_i);
    end
    $display("Finished with no errors");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb/mc_node_model.sv ====
//////////////////////////////////////////////////////////////////////
// mesh endpoint; loads answered in order, credits after 1 to 4 cycles
//////////////////////////////////////////////////////////////////////
`include "mc_bridge_defs.svh"
`timescale 1ns/1ps
`default_nettype none

module mc_node_model (
  input  wire logic                       clk_i,
  input  wire logic                       reset_i,
  input  wire logic                       pkt_v_i,
  input  wire mc_bridge_pkg::pkt_op_e     pkt_op_i,
  input  wire logic [`MC_X_W-1:0]         pkt_x_i,
  input  wire logic [`MC_Y_W-1:0]         pkt_y_i,
  input  wire logic [`MC_LINK_ADDR_W-1:0] pkt_addr_i,
  input  wire logic [`MC_WORD_W-1:0]      pkt_data_i,
  output logic                            credit_o,
  output logic                            return_v_o,
  output logic [`MC_WORD_W-1:0]           return_data_o,
  output int                              in_flight_o
);

  localparam int idx_w = `MC_X_W + `MC_Y_W + `MC_LINK_ADDR_W;

  logic [`MC_WORD_W-1:0] mem [0:(1<<idx_w)-1];
  logic [`MC_WORD_W-1:0] ret_data [$];
  int ret_due [$];
  int credit_due [$];
  int seed;
  int cyc;
  logic give;
  logic [idx_w-1:0] idx;

  initial begin
    seed = 32'hd388;
    for (int i = 0; i < (1 << idx_w); i++) begin
      mem[i] = i ^ 32'ha5c3_96e1;
    end
  end

  always @(posedge clk_i) begin
    if (reset_i) begin
      cyc = 0;
      credit_due.delete();
      ret_due.delete();
      ret_data.delete();
      credit_o    <= 1'b0;
      return_v_o  <= 1'b0;
      in_flight_o <= 0;
    end else begin
      cyc = cyc + 1;
      give = 1'b0;
      credit_o   <= 1'b0;
      return_v_o <= 1'b0;
      // one credit and one return word per cycle at most
      if (credit_due.size() > 0 && credit_due[0] <= cyc) begin
        void'(credit_due.pop_front());
        credit_o <= 1'b1;
        give = 1'b1;
      end
      if (ret_due.size() > 0 && ret_due[0] <= cyc) begin
        void'(ret_due.pop_front());
        return_v_o    <= 1'b1;
        return_data_o <= ret_data.pop_front();
      end
      if (pkt_v_i) begin
        idx = {pkt_y_i, pkt_x_i, pkt_addr_i};
        credit_due.push_back(cyc + 1 + ($unsigned($random(seed)) % 4));
        if (pkt_op_i == mc_bridge_pkg::PKT_STORE) begin
          mem[idx] = pkt_data_i;
        end else begin
          ret_due.push_back(cyc + 1 + ($unsigned($random(seed)) % 4));
          ret_data.push_back(mem[idx]);
        end
      end
      in_flight_o <= in_flight_o + (pkt_v_i ? 1 : 0) - (give ? 1 : 0);
    end
  end

endmodule

`default_nettype wire
